/* hdl/rsa_pkg.sv */
// ##################################################
// shared types for the systolic engine; words wrap
// at 16 bits, addresses sized for the cov bank
// ##################################################
package rsa_pkg;

  // data word, one lane
  localparam int WORD_W = 16;
  typedef logic [WORD_W-1:0] word_t;

  // bank address, temp bank uses only the low bits
  localparam int ADDR_W = 8;
  typedef logic [ADDR_W-1:0] addr_t;

  // step count K, zero is not a valid command
  typedef logic [7:0] len_t;

  typedef enum logic {
    BANK_TEMP = 1'b0,
    BANK_COV  = 1'b1
  } bank_sel_t;

  // B_CONST reads one temp vector on the first step and reuses it
  typedef enum logic [1:0] {
    B_TEMP  = 2'd0,
    B_COV   = 2'd1,
    B_CONST = 2'd2
  } b_src_t;

  // one command, 36 bits
  typedef struct packed {
    bank_sel_t a_src;
    b_src_t    b_src;
    bank_sel_t c_dst;
    addr_t     a_base;
    addr_t     b_base;
    addr_t     c_base;
    len_t      len;
  } cmd_t;

endpackage

/* hdl/rsa_ifs.sv */
// ##################################################
// engine side bank port; read data one cycle after
// en with we low, writes land at the clock edge
// ##################################################
`timescale 1ns/100ps

interface bank_if
  import rsa_pkg::*;
#(
  parameter int DIM = 4
) ();

  // access strobe and direction
  logic            en;
  logic            we;

  // bank and entry
  bank_sel_t       sel;
  addr_t           addr;

  // one word per lane
  word_t [DIM-1:0] wdata;
  word_t [DIM-1:0] rdata;

  // fetch and drain side
  modport requester (
    output en,
    output we,
    output sel,
    output addr,
    output wdata,
    input  rdata
  );

  // lane_bank side
  modport memory (
    input  en,
    input  we,
    input  sel,
    input  addr,
    input  wdata,
    output rdata
  );

endinterface

/* hdl/lane_bank.sv */
// ##################################################
// temp and cov lane memories; host only gets port a
// when fetch is idle, port b is drain or fetch
// ##################################################
`timescale 1ns/100ps

module lane_bank
  import rsa_pkg::*;
#(
  parameter int DIM   = 4,
  parameter int TB_AW = 6,
  parameter int CB_AW = 8
) (
  input  logic            clk,
  input  logic            i_arst_n,
  input  logic            i_host_en,
  input  logic            i_host_we,
  input  bank_sel_t       i_host_sel,
  input  addr_t           i_host_addr,
  input  word_t [DIM-1:0] i_host_wdata,
  output word_t [DIM-1:0] o_host_rdata,
  output logic            o_host_rvalid,
  bank_if.memory          rd_a,
  bank_if.memory          rd_b,
  bank_if.memory          wr_c
);

  typedef word_t [DIM-1:0] vec_t;

  logic      a_en;
  logic      a_we;
  logic      b_en;
  logic      b_we;
  bank_sel_t a_sel;
  bank_sel_t b_sel;
  bank_sel_t a_sel_q;
  bank_sel_t b_sel_q;
  addr_t     a_addr;
  addr_t     b_addr;
  vec_t      a_wdata;
  vec_t      b_wdata;
  vec_t      a_rdata;
  vec_t      b_rdata;

  // port a, fetch wins over host
  assign a_en    = rd_a.en | i_host_en;
  assign a_we    = rd_a.en ? rd_a.we : i_host_we;
  assign a_sel   = rd_a.en ? rd_a.sel : i_host_sel;
  assign a_addr  = rd_a.en ? rd_a.addr : i_host_addr;
  assign a_wdata = rd_a.en ? rd_a.wdata : i_host_wdata;

  // port b, drain writes only after the last fetch step
  assign b_en    = wr_c.en | rd_b.en;
  assign b_we    = wr_c.en ? wr_c.we : rd_b.we;
  assign b_sel   = wr_c.en ? wr_c.sel : rd_b.sel;
  assign b_addr  = wr_c.en ? wr_c.addr : rd_b.addr;
  assign b_wdata = wr_c.en ? wr_c.wdata : rd_b.wdata;

  // bank 0 temp, bank 1 cov; same dual port body
  for (genvar g = 0; g < 2; g++) begin : g_bank
    localparam int AW = (g == 0) ? TB_AW : CB_AW;

    vec_t mem [2**AW];
    vec_t q_a;
    vec_t q_b;
    logic hit_a;
    logic hit_b;

    assign hit_a = a_en && (a_sel == bank_sel_t'(g));
    assign hit_b = b_en && (b_sel == bank_sel_t'(g));

    // read before write on each port
    always_ff @(posedge clk) begin
      if (hit_a) begin
        if (a_we) begin
          mem[a_addr[AW-1:0]] <= a_wdata;
        end
        q_a <= mem[a_addr[AW-1:0]];
      end
      if (hit_b) begin
        if (b_we) begin
          mem[b_addr[AW-1:0]] <= b_wdata;
        end
        q_b <= mem[b_addr[AW-1:0]];
      end
    end
  end

  // remember which bank answers, held between accesses
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      a_sel_q       <= BANK_TEMP;
      b_sel_q       <= BANK_TEMP;
      o_host_rvalid <= 1'b0;
    end else begin
      if (a_en) begin
        a_sel_q <= a_sel;
      end
      if (b_en) begin
        b_sel_q <= b_sel;
      end
      // host read that actually got port a
      o_host_rvalid <= i_host_en & ~i_host_we & ~rd_a.en;
    end
  end

  assign a_rdata = (a_sel_q == BANK_COV) ? g_bank[1].q_a : g_bank[0].q_a;
  assign b_rdata = (b_sel_q == BANK_COV) ? g_bank[1].q_b : g_bank[0].q_b;

  assign rd_a.rdata   = a_rdata;
  assign o_host_rdata = a_rdata;
  assign rd_b.rdata   = b_rdata;
  assign wr_c.rdata   = b_rdata;

endmodule

/* hdl/rsa_sequencer.sv */
// ##################################################
// one command at a time; starts while busy or with
// len zero are dropped
// ##################################################
`timescale 1ns/100ps

module rsa_sequencer
  import rsa_pkg::*;
(
  input  logic      clk,
  input  logic      i_arst_n,
  input  logic      i_start,
  input  bank_sel_t i_a_src,
  input  b_src_t    i_b_src,
  input  bank_sel_t i_c_dst,
  input  addr_t     i_a_base,
  input  addr_t     i_b_base,
  input  addr_t     i_c_base,
  input  len_t      i_len,
  input  logic      i_drained,
  output cmd_t      o_cmd,
  output logic      o_step,
  output len_t      o_k,
  output logic      o_first,
  output logic      o_last,
  output logic      o_busy,
  output logic      o_done
);

  cmd_t cmd_q;
  len_t k_q;
  logic busy_q;
  logic run_q;
  logic done_q;
  logic accept;

  assign accept = i_start && !busy_q && (i_len != '0);

  // command fields, held until the next accepted start
  always_ff @(posedge clk) begin
    if (accept) begin
      cmd_q <= '{
        a_src:  i_a_src,
        b_src:  i_b_src,
        c_dst:  i_c_dst,
        a_base: i_a_base,
        b_base: i_b_base,
        c_base: i_c_base,
        len:    i_len
      };
    end
  end

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      busy_q <= 1'b0;
      run_q  <= 1'b0;
      done_q <= 1'b0;
      k_q    <= '0;
    end else begin
      done_q <= 1'b0;
      if (accept) begin
        busy_q <= 1'b1;
        run_q  <= 1'b1;
        k_q    <= '0;
      end else begin
        // one step per cycle, back to back
        if (run_q) begin
          k_q <= k_q + 8'd1;
          if (o_last) begin
            run_q <= 1'b0;
          end
        end
        // array drained, busy drops with the done pulse
        if (busy_q && !run_q && i_drained) begin
          busy_q <= 1'b0;
          done_q <= 1'b1;
        end
      end
    end
  end

  assign o_cmd   = cmd_q;
  assign o_step  = run_q;
  assign o_k     = k_q;
  assign o_first = run_q && (k_q == '0);
  assign o_last  = run_q && (k_q == cmd_q.len - 8'd1);
  assign o_busy  = busy_q;
  assign o_done  = done_q;

endmodule

/* hdl/operand_fetch.sv */
// ##################################################
// DIM >= 2; lane i of A and flags, lane j of B leave
// i or j cycles after the bank data
// ##################################################
`timescale 1ns/100ps

module operand_fetch
  import rsa_pkg::*;
#(
  parameter int DIM = 4
) (
  input  logic            clk,
  input  logic            i_arst_n,
  input  cmd_t            i_cmd,
  input  logic            i_step,
  input  len_t            i_k,
  input  logic            i_first,
  input  logic            i_last,
  bank_if.requester       rd_a,
  bank_if.requester       rd_b,
  output word_t [DIM-1:0] o_a_vec,
  output word_t [DIM-1:0] o_b_vec,
  output logic  [DIM-1:0] o_valid,
  output logic  [DIM-1:0] o_first,
  output logic  [DIM-1:0] o_last
);

  typedef word_t [DIM-1:0] vec_t;

  logic           v_q;
  logic           f_q;
  logic           l_q;
  logic           is_const;
  vec_t           cbuf_q;
  vec_t           b_in;
  vec_t           a_dl [1:DIM-1];
  vec_t           b_dl [1:DIM-1];
  logic [DIM-1:1] v_dl;
  logic [DIM-1:1] f_dl;
  logic [DIM-1:1] l_dl;

  assign is_const = (i_cmd.b_src == B_CONST);

  // A at a_base+k
  assign rd_a.en    = i_step;
  assign rd_a.we    = 1'b0;
  assign rd_a.sel   = i_cmd.a_src;
  assign rd_a.addr  = i_cmd.a_base + i_k;
  assign rd_a.wdata = '0;

  // B at b_base+k, const mode reads b_base once
  assign rd_b.en    = i_step && (!is_const || i_first);
  assign rd_b.we    = 1'b0;
  assign rd_b.sel   = (i_cmd.b_src == B_COV) ? BANK_COV : BANK_TEMP;
  assign rd_b.addr  = is_const ? i_cmd.b_base : i_cmd.b_base + i_k;
  assign rd_b.wdata = '0;

  // flags follow the bank read latency, then the skew line
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      v_q  <= 1'b0;
      f_q  <= 1'b0;
      l_q  <= 1'b0;
      v_dl <= '0;
      f_dl <= '0;
      l_dl <= '0;
    end else begin
      v_q     <= i_step;
      f_q     <= i_first;
      l_q     <= i_last;
      v_dl[1] <= v_q;
      f_dl[1] <= f_q;
      l_dl[1] <= l_q;
      for (int s = 2; s < DIM; s++) begin
        v_dl[s] <= v_dl[s-1];
        f_dl[s] <= f_dl[s-1];
        l_dl[s] <= l_dl[s-1];
      end
    end
  end

  // constant B vector, caught on the first step
  always_ff @(posedge clk) begin
    if (v_q && f_q && is_const) begin
      cbuf_q <= rd_b.rdata;
    end
  end

  assign b_in = (is_const && !f_q) ? cbuf_q : rd_b.rdata;

  // skew lines, only the diagonal reaches the array
  always_ff @(posedge clk) begin
    a_dl[1] <= rd_a.rdata;
    b_dl[1] <= b_in;
    for (int s = 2; s < DIM; s++) begin
      a_dl[s] <= a_dl[s-1];
      b_dl[s] <= b_dl[s-1];
    end
  end

  always_comb begin
    o_a_vec[0] = rd_a.rdata[0];
    o_b_vec[0] = b_in[0];
    o_valid[0] = v_q;
    o_first[0] = f_q;
    o_last[0]  = l_q;
    for (int i = 1; i < DIM; i++) begin
      o_a_vec[i] = a_dl[i][i];
      o_b_vec[i] = b_dl[i][i];
      o_valid[i] = v_dl[i];
      o_first[i] = f_dl[i];
      o_last[i]  = l_dl[i];
    end
  end

endmodule

/* hdl/pe_mac.sv */
// ##################################################
// one MAC cell, wraps modulo 2^16
// ##################################################
`timescale 1ns/100ps

module pe_mac
  import rsa_pkg::*;
(
  input  logic  clk,
  input  logic  i_arst_n,
  input  word_t i_a,
  input  word_t i_b,
  input  logic  i_valid,
  input  logic  i_first,
  input  logic  i_last,
  output word_t o_a,
  output word_t o_b,
  output logic  o_valid,
  output logic  o_first,
  output logic  o_last,
  output word_t o_acc
);

  word_t prod;

  // low half of the product only
  assign prod = i_a * i_b;

  // first step reloads, later steps add
  always_ff @(posedge clk) begin
    o_a <= i_a;
    o_b <= i_b;
    if (i_valid) begin
      o_acc <= i_first ? prod : o_acc + prod;
    end
  end

  // flags ride east with a
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_valid <= 1'b0;
      o_first <= 1'b0;
      o_last  <= 1'b0;
    end else begin
      o_valid <= i_valid;
      o_first <= i_first;
      o_last  <= i_last;
    end
  end

endmodule

/* hdl/pe_array.sv */
// ##################################################
// DIM x DIM grid; A and flags move east, B north
// ##################################################
`timescale 1ns/100ps

module pe_array
  import rsa_pkg::*;
#(
  parameter int DIM = 4
) (
  input  logic                       clk,
  input  logic                       i_arst_n,
  input  word_t [DIM-1:0]            i_a_vec,
  input  word_t [DIM-1:0]            i_b_vec,
  input  logic  [DIM-1:0]            i_valid,
  input  logic  [DIM-1:0]            i_first,
  input  logic  [DIM-1:0]            i_last,
  output word_t [DIM-1:0][DIM-1:0]   o_acc,
  output logic                       o_last_done
);

  // extra column and row take the edge outputs
  word_t a_w [DIM][DIM+1];
  word_t b_w [DIM+1][DIM];
  logic  v_w [DIM][DIM+1];
  logic  f_w [DIM][DIM+1];
  logic  l_w [DIM][DIM+1];

  for (genvar i = 0; i < DIM; i++) begin : g_row
    // west edge, row i
    assign a_w[i][0] = i_a_vec[i];
    assign v_w[i][0] = i_valid[i];
    assign f_w[i][0] = i_first[i];
    assign l_w[i][0] = i_last[i];
    // south edge, column i
    assign b_w[0][i] = i_b_vec[i];

    for (genvar j = 0; j < DIM; j++) begin : g_col
      pe_mac u_pe (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .i_a      (a_w[i][j]),
        .i_b      (b_w[i][j]),
        .i_valid  (v_w[i][j]),
        .i_first  (f_w[i][j]),
        .i_last   (l_w[i][j]),
        .o_a      (a_w[i][j+1]),
        .o_b      (b_w[i+1][j]),
        .o_valid  (v_w[i][j+1]),
        .o_first  (f_w[i][j+1]),
        .o_last   (l_w[i][j+1]),
        .o_acc    (o_acc[i][j])
      );
    end
  end

  // corner cell sees the last step, its acc is final next cycle
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_last_done <= 1'b0;
    end else begin
      o_last_done <= v_w[DIM-1][DIM-1] & l_w[DIM-1][DIM-1];
    end
  end

endmodule

/* hdl/result_drain.sv */
// ##################################################
// DIM >= 2; one C row per cycle into c_dst
// ##################################################
`timescale 1ns/100ps

module result_drain
  import rsa_pkg::*;
#(
  parameter int DIM = 4
) (
  input  logic                     clk,
  input  logic                     i_arst_n,
  input  cmd_t                     i_cmd,
  input  word_t [DIM-1:0][DIM-1:0] i_acc,
  input  logic                     i_last_done,
  bank_if.requester                wr_c,
  output logic                     o_drained
);

  localparam int RW = $clog2(DIM);

  word_t [DIM-1:0][DIM-1:0] acc_q;
  logic  [RW-1:0]           row_q;
  logic                     act_q;
  logic                     row_end;

  assign row_end = (row_q == RW'(DIM - 1));

  // snapshot, array is free for the next command
  always_ff @(posedge clk) begin
    if (i_last_done) begin
      acc_q <= i_acc;
    end
  end

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      act_q     <= 1'b0;
      row_q     <= '0;
      o_drained <= 1'b0;
    end else begin
      o_drained <= act_q && row_end;
      if (i_last_done) begin
        act_q <= 1'b1;
        row_q <= '0;
      end else if (act_q) begin
        row_q <= row_q + 1'b1;
        if (row_end) begin
          act_q <= 1'b0;
        end
      end
    end
  end

  // row i to c_base+i, lane j is column j
  assign wr_c.en    = act_q;
  assign wr_c.we    = act_q;
  assign wr_c.sel   = i_cmd.c_dst;
  assign wr_c.addr  = i_cmd.c_base + addr_t'(row_q);
  assign wr_c.wdata = acc_q[row_q];

endmodule

/* hdl/rsa_top.sv */
// ##################################################
// host port only while o_busy is low
// ##################################################
`timescale 1ns/100ps

module rsa_top
  import rsa_pkg::*;
#(
  parameter int DIM   = 4,
  parameter int TB_AW = 6,
  parameter int CB_AW = 8
) (
  input  logic            clk,
  input  logic            i_arst_n,
  input  logic            i_start,
  input  bank_sel_t       i_a_src,
  input  b_src_t          i_b_src,
  input  bank_sel_t       i_c_dst,
  input  addr_t           i_a_base,
  input  addr_t           i_b_base,
  input  addr_t           i_c_base,
  input  len_t            i_len,
  output logic            o_busy,
  output logic            o_done,
  input  logic            i_host_en,
  input  logic            i_host_we,
  input  bank_sel_t       i_host_sel,
  input  addr_t           i_host_addr,
  input  word_t [DIM-1:0] i_host_wdata,
  output word_t [DIM-1:0] o_host_rdata,
  output logic            o_host_rvalid
);

  // sequencer to fetch and drain
  cmd_t cmd;
  logic step;
  len_t k;
  logic first;
  logic last;
  logic drained;

  // fetch to array
  word_t [DIM-1:0] a_vec;
  word_t [DIM-1:0] b_vec;
  logic  [DIM-1:0] lane_valid;
  logic  [DIM-1:0] lane_first;
  logic  [DIM-1:0] lane_last;

  // array to drain
  word_t [DIM-1:0][DIM-1:0] acc;
  logic                     last_done;

  bank_if #(.DIM(DIM)) rd_a ();
  bank_if #(.DIM(DIM)) rd_b ();
  bank_if #(.DIM(DIM)) wr_c ();

  rsa_sequencer u_seq (
    .clk       (clk),
    .i_arst_n  (i_arst_n),
    .i_start   (i_start),
    .i_a_src   (i_a_src),
    .i_b_src   (i_b_src),
    .i_c_dst   (i_c_dst),
    .i_a_base  (i_a_base),
    .i_b_base  (i_b_base),
    .i_c_base  (i_c_base),
    .i_len     (i_len),
    .i_drained (drained),
    .o_cmd     (cmd),
    .o_step    (step),
    .o_k       (k),
    .o_first   (first),
    .o_last    (last),
    .o_busy    (o_busy),
    .o_done    (o_done)
  );

  operand_fetch #(.DIM(DIM)) u_fetch (
    .clk      (clk),
    .i_arst_n (i_arst_n),
    .i_cmd    (cmd),
    .i_step   (step),
    .i_k      (k),
    .i_first  (first),
    .i_last   (last),
    .rd_a     (rd_a.requester),
    .rd_b     (rd_b.requester),
    .o_a_vec  (a_vec),
    .o_b_vec  (b_vec),
    .o_valid  (lane_valid),
    .o_first  (lane_first),
    .o_last   (lane_last)
  );

  pe_array #(.DIM(DIM)) u_array (
    .clk         (clk),
    .i_arst_n    (i_arst_n),
    .i_a_vec     (a_vec),
    .i_b_vec     (b_vec),
    .i_valid     (lane_valid),
    .i_first     (lane_first),
    .i_last      (lane_last),
    .o_acc       (acc),
    .o_last_done (last_done)
  );

  result_drain #(.DIM(DIM)) u_drain (
    .clk         (clk),
    .i_arst_n    (i_arst_n),
    .i_cmd       (cmd),
    .i_acc       (acc),
    .i_last_done (last_done),
    .wr_c        (wr_c.requester),
    .o_drained   (drained)
  );

  lane_bank #(
    .DIM   (DIM),
    .TB_AW (TB_AW),
    .CB_AW (CB_AW)
  ) u_bank (
    .clk           (clk),
    .i_arst_n      (i_arst_n),
    .i_host_en     (i_host_en),
    .i_host_we     (i_host_we),
    .i_host_sel    (i_host_sel),
    .i_host_addr   (i_host_addr),
    .i_host_wdata  (i_host_wdata),
    .o_host_rdata  (o_host_rdata),
    .o_host_rvalid (o_host_rvalid),
    .rd_a          (rd_a.memory),
    .rd_b          (rd_b.memory),
    .wr_c          (wr_c.memory)
  );

endmodule

/* testbench/rsa_tb_clk.sv */
// ##################################################
// 40 ns clock, reset low for the first 4 rising edges
// ##################################################
`timescale 1ns/100ps

module rsa_tb_clk (
  output logic o_clk,
  output logic o_arst_n
);

  // free running, half period 20 ns
  initial begin
    o_clk = 1'b0;
    forever #20 o_clk = ~o_clk;
  end

  // release just after the 4th edge, clear of the sampling point
  initial begin
    o_arst_n = 1'b0;
    repeat (4) @(posedge o_clk);
    #2 o_arst_n = 1'b1;
  end

endmodule

/* testbench/rsa_props.sv */
// ##################################################
// host reads assumed only while o_busy is low
// ##################################################
`timescale 1ns/100ps

module rsa_props (
  input logic clk,
  input logic i_arst_n,
  input logic i_start,
  input logic i_host_en,
  input logic i_host_we,
  input logic o_busy,
  input logic o_done,
  input logic o_host_rvalid
);

  // read by the testbench at the end
  int fail_cnt = 0;

  // done marks the end, busy already low
  assert property (@(posedge clk) disable iff (!i_arst_n) o_done |-> !o_busy)
    else begin $error("o_done seen with o_busy high"); fail_cnt++; end

  assert property (@(posedge clk) disable iff (!i_arst_n) o_done |=> !o_done)
    else begin $error("o_done longer than one cycle"); fail_cnt++; end

  // idle host read answers on the next cycle
  assert property (@(posedge clk) disable iff (!i_arst_n)
    (i_host_en && !i_host_we && !o_busy) |=> o_host_rvalid)
    else begin $error("host read without o_host_rvalid"); fail_cnt++; end

  assert property (@(posedge clk) disable iff (!i_arst_n)
    o_host_rvalid |-> $past(i_host_en && !i_host_we))
    else begin $error("o_host_rvalid without a host read"); fail_cnt++; end

  // busy only follows a start
  assert property (@(posedge clk) disable iff (!i_arst_n) $rose(o_busy) |-> $past(i_start))
    else begin $error("o_busy rose without a start"); fail_cnt++; end

endmodule

bind rsa_top rsa_props u_props (
  .clk           (clk),
  .i_arst_n      (i_arst_n),
  .i_start       (i_start),
  .i_host_en     (i_host_en),
  .i_host_we     (i_host_we),
  .o_busy        (o_busy),
  .o_done        (o_done),
  .o_host_rvalid (o_host_rvalid)
);

/* testbench/rsa_tb.sv */
// ##################################################
// DIM 4; host traffic only between commands, mirror
// model of both banks kept in step with every write
// ##################################################
`timescale 1ns/100ps

module rsa_tb
  import rsa_pkg::*;
();

  localparam int DIM   = 4;
  localparam int TB_AW = 6;
  localparam int CB_AW = 8;
  localparam int TMO   = 1000;
  localparam int NROW  = 7;

  typedef word_t [DIM-1:0] vec_t;

  // one command row, poke pulses a second start mid run
  typedef struct {
    string     name;
    bank_sel_t a_src;
    b_src_t    b_src;
    bank_sel_t c_dst;
    addr_t     a_base;
    addr_t     b_base;
    addr_t     c_base;
    len_t      len;
    logic      poke;
  } row_t;

  logic      clk;
  logic      arst_n;
  logic      start;
  bank_sel_t a_src;
  b_src_t    b_src;
  bank_sel_t c_dst;
  addr_t     a_base;
  addr_t     b_base;
  addr_t     c_base;
  len_t      len;
  logic      busy;
  logic      done;
  logic      host_en;
  logic      host_we;
  bank_sel_t host_sel;
  addr_t     host_addr;
  vec_t      host_wdata;
  vec_t      host_rdata;
  logic      host_rvalid;

  // row 3 reads the temp rows written by row 2
  row_t tbl [NROW] = '{
    '{"a_temp_b_cov", BANK_TEMP, B_COV,   BANK_TEMP, 8'd0,  8'd10, 8'd40,  8'd5,   1'b0},
    '{"b_const",      BANK_COV,  B_CONST, BANK_COV,  8'd20, 8'd5,  8'd200, 8'd7,   1'b0},
    '{"chain_src",    BANK_TEMP, B_TEMP,  BANK_TEMP, 8'd8,  8'd16, 8'd48,  8'd6,   1'b0},
    '{"chain_use",    BANK_TEMP, B_COV,   BANK_COV,  8'd48, 8'd100, 8'd210, 8'd4,  1'b0},
    '{"len_zero",     BANK_TEMP, B_TEMP,  BANK_TEMP, 8'd0,  8'd0,  8'd0,   8'd0,   1'b0},
    '{"start_busy",   BANK_COV,  B_TEMP,  BANK_TEMP, 8'd30, 8'd0,  8'd56,  8'd9,   1'b1},
    '{"wrap_k255",    BANK_COV,  B_COV,   BANK_TEMP, 8'd0,  8'd1,  8'd60,  8'd255, 1'b0}
  };

  vec_t        temp_m [2**TB_AW];
  vec_t        cov_m [2**CB_AW];
  word_t       exp_c [DIM][DIM];
  logic [31:0] seed = 32'h1e92_d738;
  int          n_chk = 0;
  int          n_err = 0;
  int          n_tmo = 0;

  rsa_tb_clk u_clk (.o_clk(clk), .o_arst_n(arst_n));

  rsa_top #(.DIM(DIM), .TB_AW(TB_AW), .CB_AW(CB_AW)) rsa_top_i (
    .clk(clk), .i_arst_n(arst_n), .i_start(start), .i_a_src(a_src), .i_b_src(b_src),
    .i_c_dst(c_dst), .i_a_base(a_base), .i_b_base(b_base), .i_c_base(c_base),
    .i_len(len), .o_busy(busy), .o_done(done), .i_host_en(host_en),
    .i_host_we(host_we), .i_host_sel(host_sel), .i_host_addr(host_addr),
    .i_host_wdata(host_wdata), .o_host_rdata(host_rdata), .o_host_rvalid(host_rvalid)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // temp bank decodes only the low address bits
  function automatic vec_t mirror_rd(input bank_sel_t sel, input addr_t a);
    return (sel == BANK_COV) ? cov_m[a] : temp_m[a[TB_AW-1:0]];
  endfunction

  task automatic mirror_wr(input bank_sel_t sel, input addr_t a, input vec_t v);
    if (sel == BANK_COV) cov_m[a] = v;
    else temp_m[a[TB_AW-1:0]] = v;
  endtask

  task automatic tick();
    @(posedge clk);
    #2;
  endtask

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    n_chk++;
    if (exp !== act) begin
      n_err++;
      $display("ERR %s exp %h act %h", name, exp, act);
    end
  endtask

  task automatic host_write(input bank_sel_t sel, input addr_t a, input vec_t v);
    host_en = 1'b1;
    host_we = 1'b1;
    host_sel = sel;
    host_addr = a;
    host_wdata = v;
    tick();
    host_en = 1'b0;
    mirror_wr(sel, a, v);
  endtask

  // data and valid are due one cycle after the request
  task automatic host_read(input string name, input bank_sel_t sel, input addr_t a,
                           output vec_t d);
    host_en = 1'b1;
    host_we = 1'b0;
    host_sel = sel;
    host_addr = a;
    tick();
    host_en = 1'b0;
    check({name, " rvalid"}, 1, host_rvalid);
    d = host_rdata;
  endtask

  // C[i][j] = sum over k of A[k][i] * B[k][j], wrapping at 16 bits
  task automatic compute_expected(input row_t t);
    vec_t av;
    vec_t bv;
    for (int i = 0; i < DIM; i++) begin
      for (int j = 0; j < DIM; j++) exp_c[i][j] = '0;
    end
    for (int k = 0; k < int'(t.len); k++) begin
      av = mirror_rd(t.a_src, addr_t'(t.a_base + k));
      if (t.b_src == B_CONST) bv = mirror_rd(BANK_TEMP, t.b_base);
      else bv = mirror_rd((t.b_src == B_COV) ? BANK_COV : BANK_TEMP, addr_t'(t.b_base + k));
      for (int i = 0; i < DIM; i++) begin
        for (int j = 0; j < DIM; j++) exp_c[i][j] = exp_c[i][j] + word_t'(av[i] * bv[j]);
      end
    end
  endtask

  task automatic run_row(input row_t t);
    vec_t rd;
    vec_t v;
    int   n;
    if (t.len != 0) compute_expected(t);
    a_src = t.a_src;
    b_src = t.b_src;
    c_dst = t.c_dst;
    a_base = t.a_base;
    b_base = t.b_base;
    c_base = t.c_base;
    len = t.len;
    start = 1'b1;
    tick();
    start = 1'b0;
    if (t.len == 0) begin
      // nothing may start, nothing may finish
      for (n = 0; n < 50; n++) begin
        check({t.name, " busy"}, 0, busy);
        check({t.name, " done"}, 0, done);
        tick();
      end
      return;
    end
    check({t.name, " busy"}, 1, busy);
    for (n = 0; n < TMO && !done; n++) begin
      tick();
      // second start with other fields, must be dropped
      start = t.poke && (n == 3);
      if (start) begin
        len = 8'd2;
        c_base = 8'd0;
      end
    end
    start = 1'b0;
    if (!done) begin
      n_tmo++;
      $display("timeout waiting for o_done in %s", t.name);
    end
    tick();
    for (int i = 0; i < DIM; i++) begin
      host_read(t.name, t.c_dst, addr_t'(t.c_base + i), rd);
      for (int j = 0; j < DIM; j++) begin
        check($sformatf("%s c[%0d][%0d]", t.name, i, j), exp_c[i][j], rd[j]);
        v[j] = exp_c[i][j];
      end
      mirror_wr(t.c_dst, addr_t'(t.c_base + i), v);
    end
  endtask

  initial begin
    vec_t v;
    vec_t rd;
    int   n;
    start = 1'b0;
    a_src = BANK_TEMP;
    b_src = B_TEMP;
    c_dst = BANK_TEMP;
    a_base = '0;
    b_base = '0;
    c_base = '0;
    len = '0;
    host_en = 1'b0;
    host_we = 1'b0;
    host_sel = BANK_TEMP;
    host_addr = '0;
    host_wdata = '0;
    for (n = 0; n < 20 && arst_n !== 1'b1; n++) @(posedge clk);
    if (arst_n !== 1'b1) begin
      n_tmo++;
      $display("reset was never released");
    end
    tick();
    // random temp words, cov words near the top of the range
    for (int a = 0; a < 2**TB_AW; a++) begin
      for (int l = 0; l < DIM; l++) begin
        seed = lcg_next(seed);
        v[l] = seed[31:16];
      end
      host_write(BANK_TEMP, addr_t'(a), v);
    end
    for (int a = 0; a < 2**CB_AW; a++) begin
      for (int l = 0; l < DIM; l++) begin
        seed = lcg_next(seed);
        v[l] = 16'hff00 | word_t'(seed[23:16]);
      end
      host_write(BANK_COV, addr_t'(a), v);
    end
    // host readback at both ends of each bank
    for (int s = 0; s < 4; s++) begin
      host_read("host_rd", bank_sel_t'(s[0]), s[1] ? 8'hff : 8'h00, rd);
      v = mirror_rd(bank_sel_t'(s[0]), s[1] ? 8'hff : 8'h00);
      for (int l = 0; l < DIM; l++) begin
        check($sformatf("host_rd %0d lane %0d", s, l), v[l], rd[l]);
      end
      tick();
      check("host_rd rvalid low", 0, host_rvalid);
    end
    for (int r = 0; r < NROW; r++) run_row(tbl[r]);
    $display("checks %0d, value errors %0d, timeouts %0d, assertion failures %0d",
             n_chk, n_err, n_tmo, rsa_top_i.u_props.fail_cnt);
    if (n_err == 0 && n_tmo == 0 && rsa_top_i.u_props.fail_cnt == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

/* compile.f */
hdl/rsa_pkg.sv
hdl/rsa_ifs.sv
hdl/lane_bank.sv
hdl/rsa_sequencer.sv
hdl/operand_fetch.sv
hdl/pe_mac.sv
hdl/pe_array.sv
hdl/result_drain.sv
hdl/rsa_top.sv
testbench/rsa_tb_clk.sv
testbench/rsa_props.sv
testbench/rsa_tb.sv
